// ==== balanceBot.f ====
+incdir+hdl
hdl/balancePkg.sv
hdl/angleRx.sv
hdl/pidController.sv
hdl/motorDriver.sv
hdl/segDisplay.sv
hdl/balanceBot.sv
dv/clockGen.sv
dv/balanceBot_asserts.sv
dv/scoreboard.sv
dv/tbTop.sv

// ==== run.sh ====
#!/bin/sh
# build and run the balanceBot testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tbTop -f balanceBot.f -o simv \
  && ./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Done: errors found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation gave no verdict"; exit 1; }
echo "simulation PASSED"

// ==== dv/balance_input.txt ====
// angle switch duty direction badFrameFirst, all hex
// direction 0 stop, 1 forward, 2 backward
00B4 0 000 0 0  // upright, no drive
00B7 1 108 1 0
00B2 0 0CB 2 0  // negative power
00B0 1 14B 2 0
00BE 0 395 1 0
02BC 1 3FF 2 0  // pid sum wraps negative
02BC 0 3FF 2 0  // integral clips at 3FF
00B4 1 3FF 2 0
00B3 1 3A7 1 0  // clipped integral visible
0000 0 3FF 2 0
00C8 1 3FF 1 0  // forward saturation
00AF 1 0DE 1 1  // preceded by a framing error
00B4 0 38B 1 0

// ==== dv/tbTop.sv ====
`timescale 1ns/1ps
`include "balanceBot_defines.svh"

module tbTop;

  localparam int BIT_CLKS    = `BB_CLKS_PER_BIT;
  localparam int SETTLE_CLKS = `BB_CLKS_PER_BIT / 2 + 3;
  localparam int HS_LIMIT    = 5000;

  logic                   clk;
  logic                   rst;
  logic                   serialFromArduino;
  logic                   switch;
  logic [1:0]             leftDirection;
  logic [1:0]             rightDirection;
  logic                   leftSpeed;
  logic                   rightSpeed;
  logic [15:0]            led;
  logic [6:0]             seg;
  logic                   dp;
  logic [3:0]             an;
  logic                   checkReq;
  logic                   checkDone;
  logic                   finishReq;
  logic                   reportDone;
  logic [`BB_ANGLE_W-1:0] expAngle;
  logic [`BB_DUTY_W-1:0]  expDuty;
  logic [1:0]             expDir;
  int                     runErrors;
  int                     assertFails;
  int                     errorTotal;

  clockGen i_clockGen (
    .clk(clk),
    .rst(rst)
  );

  balanceBot i_balanceBot (
    .clk              (clk),
    .rst              (rst),
    .serialFromArduino(serialFromArduino),
    .leftDirection    (leftDirection),
    .rightDirection   (rightDirection),
    .leftSpeed        (leftSpeed),
    .rightSpeed       (rightSpeed),
    .switch           (switch),
    .led              (led),
    .seg              (seg),
    .dp               (dp),
    .an               (an)
  );

  // failure count of the bound assertions
  assign assertFails = i_balanceBot.i_balanceBotAsserts.failCount;

  scoreboard i_scoreboard (
    .clk           (clk),
    .rst           (rst),
    .leftDirection (leftDirection),
    .rightDirection(rightDirection),
    .leftSpeed     (leftSpeed),
    .rightSpeed    (rightSpeed),
    .switch        (switch),
    .led           (led),
    .seg           (seg),
    .dp            (dp),
    .an            (an),
    .checkReq      (checkReq),
    .expAngle      (expAngle),
    .expDuty       (expDuty),
    .expDir        (expDir),
    .finishReq     (finishReq),
    .runErrors     (runErrors),
    .assertFails   (assertFails),
    .checkDone     (checkDone),
    .reportDone    (reportDone),
    .errorTotal    (errorTotal)
  );

  // one bit, driven 5 ns after the edge, held a full bit period
  task automatic sendBit(input logic value);
    int i;
    @(posedge clk);
    #5 serialFromArduino = value;
    for (i = 1; i < BIT_CLKS; i++) begin
      @(posedge clk);
    end
  endtask

  // 8N1, lsb first
  task automatic sendByte(input logic [7:0] data, input logic stopBit);
    int i;
    sendBit(1'b0);
    for (i = 0; i < 8; i++) begin
      sendBit(data[i]);
    end
    sendBit(stopBit);
  endtask

  task automatic idleBits(input int count);
    int i;
    for (i = 0; i < count; i++) begin
      sendBit(1'b1);
    end
  endtask

  task automatic waitCheckDone(input logic level);
    int waitCnt;
    waitCnt = 0;
    while (checkDone !== level && waitCnt < HS_LIMIT) begin
      @(posedge clk);
      waitCnt++;
    end
    if (checkDone !== level) begin
      runErrors++;
      $display("timeout waiting for the scoreboard frame handshake");
    end
  endtask

  task automatic waitForReset();
    int waitCnt;
    waitCnt = 0;
    while (rst !== 1'b0 && waitCnt < 20) begin
      @(posedge clk);
      waitCnt++;
    end
    if (rst !== 1'b0) begin
      runErrors++;
      $display("timeout: reset was never released");
    end
  endtask

  task automatic runFrame(input logic [15:0] angle, input logic sw, input logic [9:0] duty,
                          input logic [1:0] dir, input logic badFirst);
    int i;
    @(posedge clk);
    #5 switch = sw;
    idleBits($urandom_range(20));
    if (badFirst) begin
      // good low byte, then a high byte with a low stop bit
      sendByte(8'h34, 1'b1);
      sendByte(8'h12, 1'b0);
      idleBits(2);
    end
    sendByte(angle[7:0], 1'b1);
    sendByte(angle[15:8], 1'b1);
    // end of stop bit, then settle time
    for (i = 0; i <= SETTLE_CLKS; i++) begin
      @(posedge clk);
    end
    #5;
    expAngle = angle;
    expDuty  = duty;
    expDir   = dir;
    checkReq = 1'b1;
    waitCheckDone(1'b1);
    #5 checkReq = 1'b0;
    waitCheckDone(1'b0);
  endtask

  initial begin
    string       line;
    int          fd;
    int          code;
    int          frames;
    int          waitCnt;
    logic [15:0] fAngle;
    logic        fSwitch;
    logic [9:0]  fDuty;
    logic [1:0]  fDir;
    logic        fBad;
    serialFromArduino = 1'b1;
    switch     = 1'b0;
    checkReq   = 1'b0;
    finishReq  = 1'b0;
    expAngle   = '0;
    expDuty    = '0;
    expDir     = '0;
    runErrors  = 0;
    frames     = 0;
    void'($urandom(87081));
    waitForReset();
    fd = $fopen("dv/balance_input.txt", "r");
    if (fd == 0) begin
      runErrors++;
      $display("could not open dv/balance_input.txt");
    end else begin
      // comment lines fail the scan and are skipped
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && $sscanf(line, "%h %h %h %h %h",
                                fAngle, fSwitch, fDuty, fDir, fBad) == 5) begin
          runFrame(fAngle, fSwitch, fDuty, fDir, fBad);
          frames++;
        end
      end
      $fclose(fd);
    end
    if (frames == 0) begin
      runErrors++;
      $display("no frames found in the input file");
    end
    @(posedge clk);
    #5 finishReq = 1'b1;
    waitCnt = 0;
    while (reportDone !== 1'b1 && waitCnt < 20) begin
      @(posedge clk);
      waitCnt++;
    end
    if (reportDone !== 1'b1) begin
      $display("timeout waiting for the scoreboard closing report");
    end
    if (reportDone === 1'b1 && errorTotal == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== dv/scoreboard.sv ====
`timescale 1ns/1ps
`include "balanceBot_defines.svh"

module scoreboard (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [1:0]             leftDirection,
  input  logic [1:0]             rightDirection,
  input  logic                   leftSpeed,
  input  logic                   rightSpeed,
  input  logic                   switch,
  input  logic [15:0]            led,
  input  logic [6:0]             seg,
  input  logic                   dp,
  input  logic [3:0]             an,
  input  logic                   checkReq,
  input  logic [`BB_ANGLE_W-1:0] expAngle,
  input  logic [`BB_DUTY_W-1:0]  expDuty,
  input  logic [1:0]             expDir,
  input  logic                   finishReq,
  input  int                     runErrors,
  input  int                     assertFails,
  output logic                   checkDone,
  output logic                   reportDone,
  output int                     errorTotal
);

  localparam int PWM_PERIOD = 1 << `BB_DUTY_W;
  localparam int DIGIT_WAIT = 8 << `BB_REFRESH_BITS;

  int mismatches = 0;
  int waitErrors = 0;

  // lit segments gfedcba for a hex digit, active high
  function automatic logic [6:0] hexSegments(input logic [3:0] nibble);
    case (nibble)
      4'h0: hexSegments = 7'h3F;
      4'h1: hexSegments = 7'h06;
      4'h2: hexSegments = 7'h5B;
      4'h3: hexSegments = 7'h4F;
      4'h4: hexSegments = 7'h66;
      4'h5: hexSegments = 7'h6D;
      4'h6: hexSegments = 7'h7D;
      4'h7: hexSegments = 7'h07;
      4'h8: hexSegments = 7'h7F;
      4'h9: hexSegments = 7'h6F;
      4'hA: hexSegments = 7'h77;
      4'hB: hexSegments = 7'h7C;
      4'hC: hexSegments = 7'h39;
      4'hD: hexSegments = 7'h5E;
      4'hE: hexSegments = 7'h79;
      default: hexSegments = 7'h71;
    endcase
  endfunction

  task automatic compareValue(input string name, input logic [15:0] expVal,
                              input logic [15:0] gotVal);
    if (gotVal !== expVal) begin
      mismatches++;
      $display("Mismatch %s expected %h got %h", name, expVal, gotVal);
    end
  endtask

  task automatic checkFrame();
    logic [15:0] shown;
    logic [3:0]  anWant;
    logic [6:0]  segWant;
    int          d;
    int          i;
    int          waitCnt;
    int          leftHigh;
    int          rightHigh;
    int          ledLeftHigh;
    int          ledRightHigh;
    // static outputs, already settled
    compareValue("led[9:0]", 16'(expDuty), 16'(led[9:0]));
    compareValue("leftDirection", 16'(expDir), 16'(leftDirection));
    compareValue("rightDirection", 16'(expDir), 16'(rightDirection));
    compareValue("led[13:10]", 16'({expDir, expDir}), 16'(led[13:10]));
    compareValue("dp", 16'(expDir[0]), 16'(dp));
    // switch high shows the angle, low the duty
    shown = switch ? expAngle : 16'(expDuty);
    for (d = 0; d < 4; d++) begin
      // active low, one digit at a time
      anWant    = 4'b1111;
      anWant[d] = 1'b0;
      waitCnt   = 0;
      while (an !== anWant && waitCnt < DIGIT_WAIT) begin
        @(negedge clk);
        waitCnt++;
      end
      if (an !== anWant) begin
        waitErrors++;
        $display("timeout waiting for the anode of digit %0d", d);
      end else begin
        segWant = ~hexSegments(shown[d*4 +: 4]);
        compareValue("seg", 16'(segWant), 16'(seg));
      end
    end
    // one full pwm period, high count equals duty
    leftHigh     = 0;
    rightHigh    = 0;
    ledLeftHigh  = 0;
    ledRightHigh = 0;
    for (i = 0; i < PWM_PERIOD; i++) begin
      @(negedge clk);
      if (leftSpeed) begin
        leftHigh++;
      end
      if (rightSpeed) begin
        rightHigh++;
      end
      // speed copies on the top led bits
      if (led[15]) begin
        ledLeftHigh++;
      end
      if (led[14]) begin
        ledRightHigh++;
      end
    end
    compareValue("leftSpeed high count", 16'(expDuty), 16'(leftHigh));
    compareValue("rightSpeed high count", 16'(expDuty), 16'(rightHigh));
    compareValue("led[15] high count", 16'(expDuty), 16'(ledLeftHigh));
    compareValue("led[14] high count", 16'(expDuty), 16'(ledRightHigh));
  endtask

  // sampled mid-cycle, away from the DUT's edges
  always @(negedge clk) begin
    if (rst) begin
      checkDone  <= 1'b0;
      reportDone <= 1'b0;
      errorTotal <= 0;
    end else begin
      if (!checkReq) begin
        checkDone <= 1'b0;
      end else if (!checkDone) begin
        checkFrame();
        checkDone <= 1'b1;
      end
      if (finishReq && !reportDone) begin
        $display("errors: %0d mismatches, %0d timeouts or run errors, %0d assertion failures",
                 mismatches, waitErrors + runErrors, assertFails);
        errorTotal <= mismatches + waitErrors + runErrors + assertFails;
        reportDone <= 1'b1;
      end
    end
  end

endmodule

// ==== dv/balanceBot_asserts.sv ====
`timescale 1ns/1ps

module balanceBotAsserts (
  input logic        clk,
  input logic        rst,
  input logic [1:0]  leftDirection,
  input logic [1:0]  rightDirection,
  input logic        leftSpeed,
  input logic        rightSpeed,
  input logic [15:0] led,
  input logic [3:0]  an
);

  // read by the testbench top for the final verdict
  int failCount = 0;

  // exactly one digit enabled, active low
  anOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(~an))
    else begin
      $error("anode select does not have exactly one low bit: %b", an);
      failCount++;
    end

  // wheels share one direction
  dirShared: assert property (@(posedge clk) disable iff (rst)
    leftDirection == rightDirection)
    else begin
      $error("left and right directions differ");
      failCount++;
    end

  // 11 would short the h-bridge
  dirLegal: assert property (@(posedge clk) disable iff (rst) leftDirection != 2'b11)
    else begin
      $error("direction code 11 driven");
      failCount++;
    end

  // zero duty, wheels idle
  speedIdle: assert property (@(posedge clk) disable iff (rst)
    (led[9:0] == 10'd0) |-> (!leftSpeed && !rightSpeed))
    else begin
      $error("wheel speed high while duty is zero");
      failCount++;
    end

endmodule

bind balanceBot balanceBotAsserts i_balanceBotAsserts (
  .clk           (clk),
  .rst           (rst),
  .leftDirection (leftDirection),
  .rightDirection(rightDirection),
  .leftSpeed     (leftSpeed),
  .rightSpeed    (rightSpeed),
  .led           (led),
  .an            (an)
);

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic rst
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset covers the first three rising edges
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #5 rst = 1'b0;
  end

endmodule

// ==== hdl/balanceBot.sv ====
`timescale 1ns/1ps
`include "balanceBot_defines.svh"

module balanceBot (
  input  logic        clk,
  input  logic        rst,
  input  logic        serialFromArduino,
  output logic [1:0]  leftDirection,
  output logic [1:0]  rightDirection,
  output logic        leftSpeed,
  output logic        rightSpeed,
  input  logic        switch,
  output logic [15:0] led,
  output logic [6:0]  seg,
  output logic        dp,
  output logic [3:0]  an
);

  logic        [`BB_ANGLE_W-1:0] angle;
  logic                          angleReady;
  logic signed [`BB_ANGLE_W-1:0] motorPower;
  logic        [`BB_DUTY_W-1:0]  duty;
  logic                          pwm;
  balancePkg::motorDir_t         direction;

  // tilt angle from the microcontroller
  angleRx i_angleRx (
    .clk              (clk),
    .rst              (rst),
    .serialFromArduino(serialFromArduino),
    .angle            (angle),
    .angleReady       (angleReady)
  );

  pidController i_pidController (
    .clk       (clk),
    .rst       (rst),
    .angle     (angle),
    .angleReady(angleReady),
    .motorPower(motorPower)
  );

  motorDriver i_motorDriver (
    .clk       (clk),
    .rst       (rst),
    .motorPower(motorPower),
    .direction (direction),
    .pwm       (pwm),
    .duty      (duty)
  );

  // debug readout
  segDisplay i_segDisplay (
    .clk       (clk),
    .rst       (rst),
    .switch    (switch),
    .duty      (duty),
    .angle     (angle),
    .angleReady(angleReady),
    .seg       (seg),
    .an        (an)
  );

  // both wheels share one direction and one speed
  assign leftDirection  = direction;
  assign rightDirection = direction;
  assign leftSpeed      = pwm;
  assign rightSpeed     = pwm;

  // led map, speeds on top, directions, then duty
  assign led = {leftSpeed, rightSpeed, leftDirection, rightDirection, duty};
  assign dp  = direction[0];

endmodule

// ==== hdl/segDisplay.sv ====
`timescale 1ns/1ps
`include "balanceBot_defines.svh"

module segDisplay (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   switch,
  input  logic [`BB_DUTY_W-1:0]  duty,
  input  logic [`BB_ANGLE_W-1:0] angle,
  input  logic                   angleReady,
  output logic [6:0]             seg,
  output logic [3:0]             an
);

  localparam int RB = `BB_REFRESH_BITS;

  logic [`BB_ANGLE_W-1:0] heldAngle;
  logic [`BB_ANGLE_W-1:0] dispNum;
  logic [RB+1:0]          refreshCnt;
  logic [1:0]             digitIdx;
  logic [3:0]             nibble;
  logic [6:0]             segNext;

  // last received angle, only kept in angle view
  always_ff @(posedge clk) begin
    if (rst || !switch) begin
      heldAngle <= '0;
    end else if (angleReady) begin
      heldAngle <= angle;
    end
  end

  // switch low shows duty, high shows angle
  assign dispNum = switch ? heldAngle : {{(`BB_ANGLE_W - `BB_DUTY_W){1'b0}}, duty};

  // top two bits pick the digit
  always_ff @(posedge clk) begin
    if (rst) begin
      refreshCnt <= '0;
    end else begin
      refreshCnt <= refreshCnt + 1'b1;
    end
  end

  assign digitIdx = refreshCnt[RB+1:RB];
  assign nibble   = dispNum[digitIdx*4 +: 4];

  // hex to active-low gfedcba
  always_comb begin
    case (nibble)
      4'h0: segNext = 7'b1000000;
      4'h1: segNext = 7'b1111001;
      4'h2: segNext = 7'b0100100;
      4'h3: segNext = 7'b0110000;
      4'h4: segNext = 7'b0011001;
      4'h5: segNext = 7'b0010010;
      4'h6: segNext = 7'b0000010;
      4'h7: segNext = 7'b1111000;
      4'h8: segNext = 7'b0000000;
      4'h9: segNext = 7'b0010000;
      4'hA: segNext = 7'b0001000;
      4'hB: segNext = 7'b0000011;
      4'hC: segNext = 7'b1000110;
      4'hD: segNext = 7'b0100001;
      4'hE: segNext = 7'b0000110;
      default: segNext = 7'b0001110;
    endcase
  end

  // anode and segments change on the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      an  <= 4'b1110;
      seg <= 7'b1111111;
    end else begin
      an  <= ~(4'b0001 << digitIdx);
      seg <= segNext;
    end
  end

endmodule

// ==== hdl/motorDriver.sv ====
`timescale 1ns/1ps
`include "balanceBot_defines.svh"

module motorDriver (
  input  logic                   clk,
  input  logic                   rst,
  input  logic signed [`BB_ANGLE_W-1:0] motorPower,
  output balancePkg::motorDir_t  direction,
  output logic                   pwm,
  output logic [`BB_DUTY_W-1:0]  duty
);

  localparam int W  = `BB_ANGLE_W;
  localparam int DW = `BB_DUTY_W;

  logic [W-1:0]  magnitude;
  logic [DW-1:0] nextDuty;
  logic [DW-1:0] pwmCnt;
  balancePkg::motorDir_t nextDir;

  // unsigned magnitude, most negative value still fits
  assign magnitude = motorPower[W-1] ? W'(-motorPower) : W'(motorPower);

  // saturate to full duty when upper bits are set
  always_comb begin
    if (|magnitude[W-1:DW]) begin
      nextDuty = '1;
    end else begin
      nextDuty = magnitude[DW-1:0];
    end
  end

  // sign selects direction, zero power stops
  always_comb begin
    if (motorPower == '0) begin
      nextDir = balancePkg::DIR_STOP;
    end else if (motorPower[W-1]) begin
      nextDir = balancePkg::DIR_BACKWARD;
    end else begin
      nextDir = balancePkg::DIR_FORWARD;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      duty      <= '0;
      direction <= balancePkg::DIR_STOP;
    end else begin
      duty      <= nextDuty;
      direction <= nextDir;
    end
  end

  // free-running pwm period counter
  always_ff @(posedge clk) begin
    if (rst) begin
      pwmCnt <= '0;
    end else begin
      pwmCnt <= pwmCnt + 1'b1;
    end
  end

  // high for duty clocks out of each period
  assign pwm = (pwmCnt < duty);

endmodule

// ==== hdl/pidController.sv ====
`timescale 1ns/1ps
`include "balanceBot_defines.svh"

module pidController (
  input  logic                          clk,
  input  logic                          rst,
  input  logic        [`BB_ANGLE_W-1:0] angle,
  input  logic                          angleReady,
  output logic signed [`BB_ANGLE_W-1:0] motorPower
);

  localparam int W = `BB_ANGLE_W;

  localparam logic signed [W-1:0] TARGET = W'(`BB_TARGET_ANGLE);
  localparam logic signed [W-1:0] KP     = W'(`BB_KP);
  localparam logic signed [W-1:0] KI     = W'(`BB_KI);
  localparam logic signed [W-1:0] KD     = W'(`BB_KD);
  // one extra bit so the running sum cannot wrap before clipping
  localparam logic signed [W:0]   POS_LIMIT = (W + 1)'(`BB_SUM_LIMIT);
  localparam logic signed [W:0]   NEG_LIMIT = -POS_LIMIT;

  logic signed [W-1:0] error;
  logic signed [W-1:0] errorSum;
  logic signed [W-1:0] errorDeriv;
  logic signed [W-1:0] prevAngle;
  logic signed [W-1:0] nextError;
  logic signed [W:0]   sumWide;
  logic signed [W-1:0] nextSum;
  logic signed [W-1:0] nextDeriv;

  // proportional input
  assign nextError = $signed(angle) - TARGET;

  // derivative per sample, no time scaling
  assign nextDeriv = $signed(angle) - prevAngle;

  // integral with sign extension before the add
  assign sumWide = {errorSum[W-1], errorSum} + {nextError[W-1], nextError};

  // clip integral to the allowed window
  always_comb begin
    if (sumWide > POS_LIMIT) begin
      nextSum = POS_LIMIT[W-1:0];
    end else if (sumWide < NEG_LIMIT) begin
      nextSum = NEG_LIMIT[W-1:0];
    end else begin
      nextSum = sumWide[W-1:0];
    end
  end

  // all terms load together on a new angle
  always_ff @(posedge clk) begin
    if (rst) begin
      error      <= '0;
      errorSum   <= '0;
      errorDeriv <= '0;
      // first derivative is taken against upright
      prevAngle  <= TARGET;
    end else if (angleReady) begin
      error      <= nextError;
      errorSum   <= nextSum;
      errorDeriv <= nextDeriv;
      prevAngle  <= $signed(angle);
    end
  end

  // pid sum, two's complement, wraps at the word width
  assign motorPower = KP * error + KI * errorSum + KD * errorDeriv;

endmodule

// ==== hdl/angleRx.sv ====
`timescale 1ns/1ps
`include "balanceBot_defines.svh"

module angleRx (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   serialFromArduino,
  output logic [`BB_ANGLE_W-1:0] angle,
  output logic                   angleReady
);

  localparam int CNT_W = $clog2(`BB_CLKS_PER_BIT);
  // start bit is checked at its middle, later bits one full period apart
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`BB_CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`BB_CLKS_PER_BIT - 1);

  logic                 rxMeta;
  logic                 rxSync;
  balancePkg::rxState_t state;
  logic [CNT_W-1:0]     bitCnt;
  logic [2:0]           bitIdx;
  logic [7:0]           shiftReg;
  logic [7:0]           lowByte;
  logic                 highByte;
  logic                 dataSample;
  logic                 stopSample;

  // two-flop synchronizer, line idles high
  always_ff @(posedge clk) begin
    if (rst) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
    end else begin
      rxMeta <= serialFromArduino;
      rxSync <= rxMeta;
    end
  end

  // mid-bit sample points
  assign dataSample = (state == balancePkg::RX_DATA) && (bitCnt == FULL_BIT);
  assign stopSample = (state == balancePkg::RX_STOP) && (bitCnt == FULL_BIT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= balancePkg::RX_IDLE;
      bitCnt     <= '0;
      bitIdx     <= '0;
      highByte   <= 1'b0;
      angleReady <= 1'b0;
    end else begin
      angleReady <= 1'b0;
      case (state)
        balancePkg::RX_IDLE: begin
          bitCnt <= '0;
          if (!rxSync) begin
            state <= balancePkg::RX_START;
          end
        end
        balancePkg::RX_START: begin
          if (bitCnt == HALF_BIT) begin
            bitCnt <= '0;
            bitIdx <= '0;
            // line back high at mid start bit means a glitch
            state  <= rxSync ? balancePkg::RX_IDLE : balancePkg::RX_DATA;
          end else begin
            bitCnt <= bitCnt + 1'b1;
          end
        end
        balancePkg::RX_DATA: begin
          if (dataSample) begin
            bitCnt <= '0;
            bitIdx <= bitIdx + 1'b1;
            if (bitIdx == 3'd7) begin
              state <= balancePkg::RX_STOP;
            end
          end else begin
            bitCnt <= bitCnt + 1'b1;
          end
        end
        balancePkg::RX_STOP: begin
          if (stopSample) begin
            bitCnt <= '0;
            state  <= balancePkg::RX_IDLE;
            if (!rxSync) begin
              // framing error, resync on a low byte
              highByte <= 1'b0;
            end else if (highByte) begin
              angleReady <= 1'b1;
              highByte   <= 1'b0;
            end else begin
              highByte <= 1'b1;
            end
          end else begin
            bitCnt <= bitCnt + 1'b1;
          end
        end
        default: state <= balancePkg::RX_IDLE;
      endcase
    end
  end

  // byte payload, lsb first
  always_ff @(posedge clk) begin
    if (dataSample) begin
      shiftReg <= {rxSync, shiftReg[7:1]};
    end
    if (stopSample && rxSync) begin
      if (highByte) begin
        angle <= {shiftReg, lowByte};
      end else begin
        lowByte <= shiftReg;
      end
    end
  end

endmodule

// ==== hdl/balancePkg.sv ====
package balancePkg;

  // serial receiver states
  typedef enum logic [1:0] {
    RX_IDLE  = 2'b00,
    RX_START = 2'b01,
    RX_DATA  = 2'b10,
    RX_STOP  = 2'b11
  } rxState_t;

  // shared wheel direction, drives the h-bridge inputs directly
  typedef enum logic [1:0] {
    DIR_STOP     = 2'b00,
    DIR_FORWARD  = 2'b01,
    DIR_BACKWARD = 2'b10
  } motorDir_t;

endpackage

// ==== hdl/balanceBot_defines.svh ====
`ifndef BALANCEBOT_DEFINES_SVH
`define BALANCEBOT_DEFINES_SVH

// width of angle, error, integral, derivative and power words
`define BB_ANGLE_W 16

// angle reading of the upright robot
`define BB_TARGET_ANGLE 180

// pid gains, tuned project-wide
`define BB_KP 77
`define BB_KI 1
`define BB_KD 10

// integral term is clipped to +/- this value
`define BB_SUM_LIMIT 1023

// clocks per serial bit, short for simulation
`define BB_CLKS_PER_BIT 16

// duty and pwm counter width
`define BB_DUTY_W 10

// each display digit is lit for 2**BB_REFRESH_BITS clocks
`define BB_REFRESH_BITS 4

`endif
